// ==== Bender.yml ====
package:
  name: update_unit

sources:
  # RTL, package first
  - files:
      - verilog/bp_pkg.sv
      - verilog/grad_scale.sv
      - verilog/vector_add.sv
      - verilog/update_unit.sv

  # Testbench and bound checks
  - target: test
    files:
      - test/update_unit_asserts.sv
      - test/tb_update_unit.sv

// ==== tb.f ====
verilog/bp_pkg.sv
verilog/grad_scale.sv
verilog/vector_add.sv
verilog/update_unit.sv
test/update_unit_asserts.sv
test/tb_update_unit.sv

// ==== test/tb_update_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_update_unit;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           start;
    logic [bp_pkg::SHIFT_WIDTH-1:0] shift;
    bp_pkg::operands_t              ops;
    bp_pkg::result_t                res;
    logic                           valid;
    logic                           busy;

    int          tb_errors = 0;
    int          op_count = 0;
    int          total_errors;
    string       test_name = "reset";
    logic [31:0] lcg_state;

    update_unit update_unit_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .shift (shift),
        .ops   (ops),
        .res   (res),
        .valid (valid),
        .busy  (busy)
    );

    // 8 ns period
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic bp_pkg::vec_t make_vec(input int c0, input int c1, input int c2,
                                              input int c3, input int c4);
        bp_pkg::vec_t v;
        v[0] = bp_pkg::cell_t'(c0);
        v[1] = bp_pkg::cell_t'(c1);
        v[2] = bp_pkg::cell_t'(c2);
        v[3] = bp_pkg::cell_t'(c3);
        v[4] = bp_pkg::cell_t'(c4);
        return v;
    endfunction

    function automatic bp_pkg::operands_t pack_ops(input bp_pkg::add_op_e op,
                                                   input bp_pkg::vec_t w, input bp_pkg::vec_t g);
        bp_pkg::operands_t o;
        o.op = op;
        o.w  = w;
        o.g  = g;
        return o;
    endfunction

    // Name shows up in the value error lines
    // Previous operation's valid edge passes under the old name first
    task automatic begin_test(input string name);
        @(negedge clk);
        test_name = name;
        update_unit_i.update_unit_asserts_i.test_name = name;
    endtask

    // One operation with an optional second start while busy
    task automatic run_op(input bp_pkg::operands_t o, input int sh, input bit poke_busy);
        int waited;
        @(negedge clk);
        ops   = o;
        shift = sh[bp_pkg::SHIFT_WIDTH-1:0];
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 1;
        if (poke_busy) begin
            @(negedge clk);
            // Swapped operands must not reach the result
            ops.w = o.g;
            ops.g = o.w;
            start = 1'b1;
            @(negedge clk);
            start  = 1'b0;
            waited = 3;
        end
        while (!valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!valid) begin
            tb_errors++;
            $display("%s: no valid pulse within 8 cycles of start", test_name);
        end
        op_count++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        bp_pkg::operands_t o;
        logic [31:0]       r;
        lcg_state = 32'd14;
        rst_n = 1'b1;
        start = 1'b0;
        shift = '0;
        ops   = '0;
        #1 rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        begin_test("plain_add_sub");
        run_op(pack_ops(bp_pkg::OP_ADD, make_vec(10, -20, 30, -40, 50),
                        make_vec(1, 2, -3, 4, -5)), 0, 1'b0);
        run_op(pack_ops(bp_pkg::OP_SUB, make_vec(10, -20, 30, -40, 50),
                        make_vec(1, 2, -3, 4, -5)), 0, 1'b0);

        // -10 >>> 2 is -3 with floor rounding
        begin_test("lr_scaling");
        for (int s = 1; s < 8; s++) begin
            run_op(pack_ops(s[0] ? bp_pkg::OP_SUB : bp_pkg::OP_ADD,
                            make_vec(40, -40, 100, -100, 0),
                            make_vec(-10, 10, -128, 127, -1)), s, 1'b0);
        end

        begin_test("saturation");
        run_op(pack_ops(bp_pkg::OP_ADD, make_vec(127, 127, 127, 127, 127),
                        make_vec(127, 127, 127, 127, 127)), 0, 1'b0);
        run_op(pack_ops(bp_pkg::OP_ADD, make_vec(-128, -128, -128, -128, -128),
                        make_vec(-128, -128, -128, -128, -128)), 0, 1'b0);
        run_op(pack_ops(bp_pkg::OP_SUB, make_vec(127, 127, 127, 127, 127),
                        make_vec(-128, -128, -128, -128, -128)), 0, 1'b0);
        // Only cell 4 in the partial last tile overflows
        run_op(pack_ops(bp_pkg::OP_ADD, make_vec(1, 2, 3, 4, 127),
                        make_vec(1, 1, 1, 1, 1)), 0, 1'b0);
        run_op(pack_ops(bp_pkg::OP_ADD, make_vec(5, 6, 7, 8, 9),
                        make_vec(1, 1, 1, 1, 1)), 0, 1'b0);

        begin_test("ignored_start");
        run_op(pack_ops(bp_pkg::OP_SUB, make_vec(60, -60, 7, 0, 33),
                        make_vec(3, 9, -9, 100, -2)), 1, 1'b1);

        begin_test("random_ops");
        for (int n = 0; n < 40; n++) begin
            r    = lcg_next();
            o.op = r[31] ? bp_pkg::OP_SUB : bp_pkg::OP_ADD;
            for (int i = 0; i < bp_pkg::VECTOR_LEN; i++) begin
                r      = lcg_next();
                o.w[i] = r[23:16];
                o.g[i] = r[15:8];
            end
            r = lcg_next();
            run_op(o, int'(r[30:28]), 1'b0);
        end

        repeat (3) @(negedge clk);
        total_errors = tb_errors + update_unit_i.update_unit_asserts_i.fail_count;
        $display("errors: %0d (assertion failures %0d, missing valid %0d) over %0d operations",
                 total_errors, update_unit_i.update_unit_asserts_i.fail_count,
                 tb_errors, op_count);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // 60 operations of 8 cycles at 8 ns plus 5 reset cycles
    initial begin
        #((60 * 8 + 5) * 8);
        $display("run timed out before all operations finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/update_unit_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Reference model and checks for update_unit
//////////////////////////////////////////////////////////////////////

module update_unit_asserts (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            start,
    input logic [bp_pkg::SHIFT_WIDTH-1:0]  shift,
    input bp_pkg::operands_t               ops,
    input bp_pkg::result_t                 res,
    input logic                            valid,
    input logic                            busy
);

    // Read by the testbench at the end of the run
    int    fail_count = 0;
    // Written by the testbench before each group of operations
    string test_name = "reset";

    logic         accept;
    bp_pkg::vec_t next_data;
    logic         next_error;
    bp_pkg::vec_t exp_data;
    logic         exp_error;

    assign accept = start && !busy;

    // Unsaturated w +/- (g >>> shift) for one cell
    function automatic int raw_update(input bp_pkg::add_op_e op, input int w, input int g,
                                      input int sh);
        int scaled;
        // int is signed, so this floors toward minus infinity
        scaled = g >>> sh;
        return (op == bp_pkg::OP_SUB) ? w - scaled : w + scaled;
    endfunction

    always_comb begin
        int sum;
        next_error = 1'b0;
        for (int i = 0; i < bp_pkg::VECTOR_LEN; i++) begin
            sum = raw_update(ops.op, ops.w[i], ops.g[i], shift);
            if (sum > int'(bp_pkg::CELL_MAX)) begin
                next_data[i] = bp_pkg::CELL_MAX;
                next_error   = 1'b1;
            end else if (sum < int'(bp_pkg::CELL_MIN)) begin
                next_data[i] = bp_pkg::CELL_MIN;
                next_error   = 1'b1;
            end else begin
                next_data[i] = bp_pkg::cell_t'(sum);
            end
        end
    end

    // Expected result of the operation in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_data  <= '0;
            exp_error <= 1'b0;
        end else if (accept) begin
            exp_data  <= next_data;
            exp_error <= next_error;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Strobes and timing
    //////////////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !valid && !busy && res == '0)
        else begin
            fail_count++;
            $error("valid, busy or result not cleared while reset is held");
        end

    // Accepted start at edge 0 gives valid sampled at edge 4
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept, 4) |-> valid && !busy)
        else begin
            fail_count++;
            $error("no valid pulse, or busy still high, four cycles after a start");
        end

    // Also catches a valid caused by an ignored start
    a_no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> $past(accept, 4))
        else begin
            fail_count++;
            $error("valid pulsed without an accepted start four cycles before");
        end

    a_busy_window: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(accept) || $past(accept, 2) || $past(accept, 3)) |-> busy && !valid)
        else begin
            fail_count++;
            $error("busy low or valid early while an operation is running");
        end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        valid |=> !valid)
        else begin
            fail_count++;
            $error("valid stayed high for more than one cycle");
        end

    // Result register only moves on the edge that raises valid
    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !valid |-> $stable(res))
        else begin
            fail_count++;
            $error("result changed while valid was low");
        end

    //////////////////////////////////////////////////////////////////////
    // Result values
    //////////////////////////////////////////////////////////////////////

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> res.data == exp_data)
        else begin
            fail_count++;
            $error("error %s: expected data %h, actual %h", test_name,
                   $sampled(exp_data), $sampled(res.data));
        end

    a_error: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> res.error == exp_error)
        else begin
            fail_count++;
            $error("error %s: expected error flag %b, actual %b", test_name,
                   $sampled(exp_error), $sampled(res.error));
        end

endmodule

bind update_unit update_unit_asserts update_unit_asserts_i (.*);

`default_nettype wire

// ==== verilog/bp_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Vector geometry
//////////////////////////////////////////////////////////////////////

package bp_pkg;

    // Cells per vector
    localparam int VECTOR_LEN = 5;

    // Signed cell width in bits
    localparam int CELL_WIDTH = 8;

    // Cells handled per clock in the adder
    localparam int TILING = 2;

    // Tile cycles per vector, rounded up
    localparam int TILE_COUNT = (VECTOR_LEN + TILING - 1) / TILING;

    // Learning-rate shift amount width
    localparam int SHIFT_WIDTH = 3;

    // One guard bit for the add/subtract
    localparam int SUM_WIDTH = CELL_WIDTH + 1;

    // Tile counter and cell index widths
    localparam int TILE_CNT_WIDTH = $clog2(TILE_COUNT);
    localparam int CELL_IDX_WIDTH = $clog2(TILE_COUNT * TILING);

    //////////////////////////////////////////////////////////////////////
    // Cell and vector types
    //////////////////////////////////////////////////////////////////////

    // One signed cell
    typedef logic signed [CELL_WIDTH-1:0] cell_t;

    // Widened sum, before saturation
    typedef logic signed [SUM_WIDTH-1:0] sum_t;

    // Cell 0 sits in the low bits
    typedef cell_t [VECTOR_LEN-1:0] vec_t;

    typedef logic [TILE_CNT_WIDTH-1:0] tile_cnt_t;
    typedef logic [CELL_IDX_WIDTH-1:0] cell_idx_t;

    // Saturation bounds, +127 and -128 for 8 bits
    localparam cell_t CELL_MAX = cell_t'(2 ** (CELL_WIDTH - 1) - 1);
    localparam cell_t CELL_MIN = cell_t'(-(2 ** (CELL_WIDTH - 1)));

    //////////////////////////////////////////////////////////////////////
    // Opcodes and bundles
    //////////////////////////////////////////////////////////////////////

    // Weight update direction
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_op_e;

    // Operation request, weights and gradients
    typedef struct packed {
        add_op_e op;
        vec_t    w;
        vec_t    g;
    } operands_t;

    // Updated weights plus overflow flag
    typedef struct packed {
        vec_t data;
        logic error;
    } result_t;

endpackage

`default_nettype wire

// ==== verilog/grad_scale.sv ====
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Gradient scaling stage
//////////////////////////////////////////////////////////////////////

// Takes one operation when idle and shifts every gradient cell
// right by the learning-rate shift before handing it to the adder

module grad_scale (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            busy,
    input  logic [bp_pkg::SHIFT_WIDTH-1:0]  shift,
    input  bp_pkg::operands_t               ops,
    output logic                            scaled_start,
    output bp_pkg::operands_t               scaled_ops
);

    // Start taken only while the adder is idle
    logic accept;

    // Gradient vector after the shift
    bp_pkg::vec_t g_shifted;

    assign accept = start && !busy;

    //////////////////////////////////////////////////////////////////////
    // Learning-rate shift
    //////////////////////////////////////////////////////////////////////

    // Arithmetic shift keeps the sign
    // Negative cells round toward minus infinity, -10 >>> 2 is -3
    always_comb begin
        for (int i = 0; i < bp_pkg::VECTOR_LEN; i++) begin
            g_shifted[i] = $signed(ops.g[i]) >>> shift;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Strobe
    //////////////////////////////////////////////////////////////////////

    // One-cycle pulse after every accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scaled_start <= 1'b0;
        end else begin
            scaled_start <= accept;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand register
    //////////////////////////////////////////////////////////////////////

    // Held until the next accepted start
    // Adder reads it on every tile cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            // Opcode and weights pass unchanged
            scaled_ops.op <= ops.op;
            scaled_ops.w  <= ops.w;
            // Gradients already scaled
            scaled_ops.g  <= g_shifted;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/update_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Weight update unit
//////////////////////////////////////////////////////////////////////

// w +/- (g >>> shift) per cell, saturated
// start to valid is 4 clocks, one for scaling and three tiles

module update_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [bp_pkg::SHIFT_WIDTH-1:0]  shift,
    input  bp_pkg::operands_t               ops,
    output bp_pkg::result_t                 res,
    output logic                            valid,
    output logic                            busy
);

    // Scaled operation toward the adder
    logic              scaled_start;
    bp_pkg::operands_t scaled_ops;

    //////////////////////////////////////////////////////////////////////
    // Scaling stage
    //////////////////////////////////////////////////////////////////////

    // Adder busy blocks new starts here
    grad_scale grad_scale_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .busy         (busy),
        .shift        (shift),
        .ops          (ops),
        .scaled_start (scaled_start),
        .scaled_ops   (scaled_ops)
    );

    //////////////////////////////////////////////////////////////////////
    // Add/subtract stage
    //////////////////////////////////////////////////////////////////////

    // Busy covers the scaled_start cycle too
    vector_add vector_add_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (scaled_start),
        .ops   (scaled_ops),
        .busy  (busy),
        .valid (valid),
        .res   (res)
    );

endmodule

`default_nettype wire

// ==== verilog/vector_add.sv ====
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Tiled saturating vector add/subtract
//////////////////////////////////////////////////////////////////////

// TILING cells per clock, TILE_COUNT clocks per vector
// Result register only changes on the last tile

module vector_add (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  bp_pkg::operands_t   ops,
    output logic                busy,
    output logic                valid,
    output bp_pkg::result_t     res
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_e;

    state_e state;

    // Next tile to process while running
    bp_pkg::tile_cnt_t tile_cnt;
    // Tile handled this cycle
    bp_pkg::tile_cnt_t tile_idx;

    // A tile is processed this cycle
    logic step;
    logic last_tile;

    // Overflow seen on earlier tiles of this operation
    logic sticky_ovf;
    logic sticky_next;

    // Partial result and its merge with the current tile
    bp_pkg::vec_t work_data;
    bp_pkg::vec_t tile_data;

    bp_pkg::result_t res_q;

    // Per-lane results
    bp_pkg::cell_t     lane_cell [bp_pkg::TILING];
    bp_pkg::cell_idx_t lane_idx  [bp_pkg::TILING];
    logic [bp_pkg::TILING-1:0] lane_hit;
    logic [bp_pkg::TILING-1:0] lane_ovf;

    //////////////////////////////////////////////////////////////////////
    // Tile select
    //////////////////////////////////////////////////////////////////////

    // Tile 0 is handled in the start cycle itself
    assign tile_idx  = (state == ST_RUN) ? tile_cnt : '0;
    assign step      = (state == ST_RUN) || ((state == ST_IDLE) && start);
    assign last_tile = tile_idx == bp_pkg::tile_cnt_t'(bp_pkg::TILE_COUNT - 1);

    // Busy from the start pulse until the last tile
    assign busy  = step;
    assign valid = state == ST_DONE;
    assign res   = res_q;

    //////////////////////////////////////////////////////////////////////
    // Lanes
    //////////////////////////////////////////////////////////////////////

    for (genvar lane = 0; lane < bp_pkg::TILING; lane++) begin : g_lane
        bp_pkg::cell_t w_cell;
        bp_pkg::cell_t g_cell;
        bp_pkg::sum_t  wide;
        logic          ovf;

        assign lane_idx[lane] = bp_pkg::cell_idx_t'(tile_idx * bp_pkg::TILING + lane);
        // Last tile is partial, upper lane falls off the vector
        assign lane_hit[lane] = lane_idx[lane] < bp_pkg::VECTOR_LEN;

        assign w_cell = lane_hit[lane] ? ops.w[lane_idx[lane]] : '0;
        assign g_cell = lane_hit[lane] ? ops.g[lane_idx[lane]] : '0;

        // Sign-extended into the guard bit
        assign wide = (ops.op == bp_pkg::OP_SUB) ? w_cell - g_cell : w_cell + g_cell;

        // Guard and top bit disagree on overflow
        assign ovf = wide[bp_pkg::CELL_WIDTH] ^ wide[bp_pkg::CELL_WIDTH-1];

        // Clamp toward the sign of the wide sum
        assign lane_cell[lane] = !ovf ? wide[bp_pkg::CELL_WIDTH-1:0] :
                                 wide[bp_pkg::CELL_WIDTH] ? bp_pkg::CELL_MIN :
                                 bp_pkg::CELL_MAX;

        assign lane_ovf[lane] = lane_hit[lane] && ovf;
    end

    // Drop the live lanes into the partial result
    always_comb begin
        tile_data = work_data;
        for (int lane = 0; lane < bp_pkg::TILING; lane++) begin
            if (lane_hit[lane]) begin
                tile_data[lane_idx[lane]] = lane_cell[lane];
            end
        end
    end

    // Cleared at start
    assign sticky_next = ((state == ST_RUN) ? sticky_ovf : 1'b0) | (|lane_ovf);

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (step) begin
            work_data <= tile_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            tile_cnt   <= '0;
            sticky_ovf <= 1'b0;
            res_q      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        sticky_ovf <= sticky_next;
                        tile_cnt   <= bp_pkg::tile_cnt_t'(1);
                        state      <= last_tile ? ST_DONE : ST_RUN;
                    end
                end
                ST_RUN: begin
                    sticky_ovf <= sticky_next;
                    tile_cnt   <= tile_cnt + 1'b1;
                    if (last_tile) begin
                        state <= ST_DONE;
                    end
                end
                // Single valid cycle
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase

            // Whole vector lands at once, stable until next valid
            if (step && last_tile) begin
                res_q.data  <= tile_data;
                res_q.error <= sticky_next;
            end
        end
    end

endmodule

`default_nettype wire
